// ==== files.f ====
+incdir+source
source/mem_pkg.sv
source/bist_pkg.sv
source/mem_if.sv
source/mem_ram.sv
source/mem_sp.sv
source/mem_access_stage.sv
source/bist_march.sv
source/mem_subsys_top.sv
sim/tb_mem_subsys.sv

// ==== Makefile ====
# Verilator flow for the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tb_mem_subsys.sv ====
//##############################
// testbench for the memory subsystem
// clock, reset and request stimulus
// shadow memory with response queue
// timing and value assertions
//##############################
`include "mem_config.svh"

module tb_mem_subsys
   import mem_pkg::*;
();

   localparam int          CLK_HALF   = 10;    // 20 unit period
   localparam int          RST_CYCLES = 4;
   localparam int          TIMEOUT    = 2000;  // cycles per wait loop
   localparam int          DEPTH      = `MEM_DEPTH;
   localparam int          NBYTES     = `MEM_NBYTES;
   localparam int unsigned SEED       = 32'h7bfb172b;

   //############################## DUT signals
   logic  clk;
   logic  arst_n;
   logic  req_valid;
   logic  req_we;
   be_t   req_be;
   addr_t req_addr;
   data_t req_data;
   tag_t  req_tag;
   logic  bist_start;
   logic  rsp_valid;
   tag_t  rsp_tag;
   data_t rsp_data;
   logic  bist_busy;
   logic  bist_done;
   logic  bist_fail;

   //############################## reference model
   data_t    shadow [DEPTH];  // expected array contents
   mem_rsp_t exp_q [$];       // reads in flight, oldest first
   logic     rd_acc;          // read accepted this edge
   int       checks;
   int       errors;
   int       tests_run;
   int       tests_failed;

   mem_subsys_top dut (
      .clk        (clk),
      .arst_n     (arst_n),
      .req_valid  (req_valid),
      .req_we     (req_we),
      .req_be     (req_be),
      .req_addr   (req_addr),
      .req_data   (req_data),
      .req_tag    (req_tag),
      .rsp_valid  (rsp_valid),
      .rsp_tag    (rsp_tag),
      .rsp_data   (rsp_data),
      .bist_start (bist_start),
      .bist_busy  (bist_busy),
      .bist_done  (bist_done),
      .bist_fail  (bist_fail)
   );

   initial clk = 1'b0;
   always #CLK_HALF clk = ~clk;

   assign rd_acc = req_valid & ~req_we & ~bist_busy;  // dropped under BIST

   // byte merge of a partial write
   function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input be_t be);
      data_t w;
      w = old_w;
      for (int b = 0; b < NBYTES; b++) begin
         if (be[b]) w[8*b +: 8] = new_w[8*b +: 8];
      end
      return w;
   endfunction

   // pre-edge values, outputs only change by nonblocking updates
   always @(posedge clk) begin
      mem_rsp_t got;
      mem_rsp_t nxt;
      if (arst_n) begin
         if (rsp_valid) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("%0t: response arrived with no read outstanding", $time);
            end else begin
               got = exp_q.pop_front();
               checks += 2;
               a_rsp_tag: assert (rsp_tag == got.tag) else begin
                  errors++;
                  $display("mismatch at %0t: rsp_tag got %h expected %h", $time, rsp_tag, got.tag);
               end
               a_rsp_data: assert (rsp_data == got.data) else begin
                  errors++;
                  $display("mismatch at %0t: rsp_data got %h expected %h",
                           $time, rsp_data, got.data);
               end
            end
         end
         if (bist_done) begin
            for (int i = 0; i < DEPTH; i++) shadow[i] = '0;  // march leaves zeros
         end
         if (req_valid && !bist_busy) begin
            if (req_we) begin
               shadow[req_addr] = merge_bytes(shadow[req_addr], req_data, req_be);
            end else begin
               nxt.tag  = req_tag;
               nxt.data = shadow[req_addr];
               exp_q.push_back(nxt);
            end
         end
      end
   end

   //############################## timing assertions
   a_rsp_on_time: assert property (@(posedge clk) disable iff (!arst_n)
      $past(rd_acc, 2) |-> rsp_valid)
      else begin
         errors++;
         $display("%0t: no response 2 cycles after an accepted read", $time);
      end

   a_rsp_wanted: assert property (@(posedge clk) disable iff (!arst_n)
      rsp_valid |-> $past(rd_acc, 2))
      else begin
         errors++;
         $display("%0t: response without an accepted read 2 cycles before", $time);
      end

   a_busy_rise: assert property (@(posedge clk) disable iff (!arst_n)
      (bist_start && !bist_busy) |=> bist_busy)
      else begin
         errors++;
         $display("%0t: bist_busy did not rise after bist_start", $time);
      end

   a_busy_fall: assert property (@(posedge clk) disable iff (!arst_n)
      $fell(bist_busy) |-> bist_done)
      else begin
         errors++;
         $display("%0t: bist_busy fell without bist_done", $time);
      end

   a_done_pass: assert property (@(posedge clk) disable iff (!arst_n)
      bist_done |-> !bist_fail)
      else begin
         errors++;
         $display("mismatch at %0t: bist_fail got %b expected 0", $time, bist_fail);
      end

   //############################## stimulus tasks
   task automatic send_req(input logic we, input be_t be, input addr_t addr,
                           input data_t data, input tag_t tag);
      @(posedge clk);
      #1;
      req_valid = 1'b1;
      req_we    = we;
      req_be    = be;
      req_addr  = addr;
      req_data  = data;
      req_tag   = tag;
   endtask

   task automatic release_req();
      @(posedge clk);
      #1;
      req_valid = 1'b0;
   endtask

   task automatic pulse_bist_start();
      @(posedge clk);
      #1;
      bist_start = 1'b1;
      @(posedge clk);
      #1;
      bist_start = 1'b0;
   endtask

   task automatic drain_rsp();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < TIMEOUT) begin
         @(posedge clk);
         #1;
         n++;
      end
      if (exp_q.size() != 0) begin
         errors++;
         $display("%0t: timeout, %0d responses never arrived", $time, exp_q.size());
      end
   endtask

   task automatic wait_bist_done();
      int n;
      n = 0;
      while (!bist_done && n < TIMEOUT) begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!bist_done) begin
         errors++;
         $display("%0t: timeout waiting for bist_done", $time);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      a_level: assert (got === exp) else begin
         errors++;
         $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic end_test(input string name, input int err_before);
      tests_run++;
      if (errors == err_before) begin
         $display("test %0d %s: done, no errors", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: done, %0d errors", tests_run, name, errors - err_before);
      end
   endtask

   //############################## test sequence
   initial begin
      int    e0;
      addr_t a;
      void'($urandom(SEED));
      checks       = 0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      req_valid    = 1'b0;
      req_we       = 1'b0;
      req_be       = '0;
      req_addr     = '0;
      req_data     = '0;
      req_tag      = '0;
      bist_start   = 1'b0;
      arst_n       = 1'b1;
      #1 arst_n = 1'b0;  // clean falling edge
      repeat (RST_CYCLES) @(posedge clk);
      #1 arst_n = 1'b1;

      e0 = errors;
      @(posedge clk);
      #1;
      check_bit("rsp_valid", rsp_valid, 1'b0);
      check_bit("bist_busy", bist_busy, 1'b0);
      check_bit("bist_done", bist_done, 1'b0);
      check_bit("bist_fail", bist_fail, 1'b0);
      end_test("reset values", e0);

      e0 = errors;
      for (int i = 0; i < DEPTH; i++) send_req(1'b1, '1, addr_t'(i), data_t'($urandom), '0);
      for (int i = 0; i < 40; i++) begin  // back to back reads
         send_req(1'b0, '0, addr_t'($urandom_range(DEPTH - 1)), '0, tag_t'($urandom));
      end
      release_req();
      drain_rsp();
      end_test("full writes, random reads", e0);

      e0 = errors;
      for (int i = 0; i < 24; i++) begin
         a = addr_t'($urandom_range(DEPTH - 1));
         send_req(1'b1, be_t'($urandom), a, data_t'($urandom), '0);
         send_req(1'b0, '0, a, '0, tag_t'(i));  // read right behind the write
      end
      release_req();
      drain_rsp();
      end_test("partial writes", e0);

      e0 = errors;
      pulse_bist_start();
      check_bit("bist_busy", bist_busy, 1'b1);
      wait_bist_done();
      check_bit("bist_fail", bist_fail, 1'b0);
      for (int i = 0; i < 16; i++) begin
         send_req(1'b0, '0, addr_t'($urandom_range(DEPTH - 1)), '0, tag_t'(i));
      end
      release_req();
      drain_rsp();
      end_test("march self test", e0);

      e0 = errors;
      pulse_bist_start();
      for (int i = 0; i < 32; i++) begin  // all dropped under busy
         send_req(i[0], '1, addr_t'($urandom_range(DEPTH - 1)), data_t'($urandom) | 1,
                  tag_t'(i));
      end
      release_req();
      wait_bist_done();
      check_bit("bist_fail", bist_fail, 1'b0);
      for (int i = 0; i < DEPTH; i++) send_req(1'b0, '0, addr_t'(i), '0, tag_t'(i));
      release_req();
      drain_rsp();
      end_test("requests during self test", e0);

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// ==== source/mem_subsys_top.sv ====
//##############################
// memory subsystem top level
// access stage, march BIST, single-port memory
//##############################

module mem_subsys_top
   import mem_pkg::*;
(
   input  logic  clk,
   input  logic  arst_n,
   // functional request
   input  logic  req_valid,  // one-cycle strobe
   input  logic  req_we,     // 1 = write
   input  be_t   req_be,     // write byte lanes
   input  addr_t req_addr,   // word address
   input  data_t req_data,   // write data
   input  tag_t  req_tag,    // read tag
   // read response
   output logic  rsp_valid,  // one-cycle strobe
   output tag_t  rsp_tag,
   output data_t rsp_data,
   // self test
   input  logic  bist_start, // one-cycle strobe
   output logic  bist_busy,
   output logic  bist_done,
   output logic  bist_fail
);

   //############################## wiring
   mem_if func_port ();  // access stage to memory
   mem_if bist_port ();  // march engine to memory

   mem_req_t req;
   mem_rsp_t rsp;
   logic     busy;  // BIST owns the array

   assign req = '{we: req_we, be: req_be, addr: req_addr, data: req_data, tag: req_tag};

   mem_access_stage u_access (
      .clk       (clk),
      .arst_n    (arst_n),
      .req_valid (req_valid),
      .req       (req),
      .bist_busy (busy),  // drop condition
      .mem       (func_port.master),
      .rsp_valid (rsp_valid),
      .rsp       (rsp)
   );

   bist_march u_bist (
      .clk        (clk),
      .arst_n     (arst_n),
      .bist_start (bist_start),
      .mem        (bist_port.master),
      .bist_busy  (busy),
      .bist_done  (bist_done),
      .bist_fail  (bist_fail)
   );

   mem_sp u_sp (
      .clk     (clk),
      .bist_en (busy),
      .func    (func_port.memory),
      .bist    (bist_port.memory)
   );

   assign bist_busy = busy;
   assign rsp_tag   = rsp.tag;
   assign rsp_data  = rsp.data;

endmodule

// ==== source/bist_march.sv ====
//##############################
// march test engine
// w0 up, r0w1 up, r1w0 down, r0 up
// one access per cycle, compare next cycle
// busy / done / sticky fail
//##############################

module bist_march
   import mem_pkg::*;
   import bist_pkg::*;
(
   input  logic  clk,
   input  logic  arst_n,
   input  logic  bist_start,  // one-cycle start strobe
   mem_if.master mem,         // BIST port of the wrapper
   output logic  bist_busy,   // level, march running
   output logic  bist_done,   // one-cycle end strobe
   output logic  bist_fail    // held until next start
);

   localparam int    DW        = $bits(data_t);
   localparam addr_t ADDR_LAST = '1;  // depth is a power of two

   //############################## sequencer state
   march_phase_e phase_q, phase_d;  // current element
   addr_t        addr_q, addr_d;    // address counter
   logic         step_q, step_d;    // 0 = read half, 1 = write half
   march_op_t    op;                // access of this cycle
   logic         access;            // phase issues an access
   logic         cmp_q;             // compare due this cycle
   logic         exp_q;             // expected bit value
   logic         done_q;
   logic         fail_q;

   always_comb begin
      phase_d = phase_q;
      addr_d  = addr_q;
      step_d  = step_q;
      case (phase_q)
         idle: begin
            if (bist_start) begin
               phase_d = w0_up;
               addr_d  = '0;
               step_d  = 1'b0;
            end
         end
         w0_up: begin
            if (addr_q == ADDR_LAST) begin
               phase_d = r0w1_up;
               addr_d  = '0;
            end else addr_d = addr_q + 1'b1;
         end
         r0w1_up: begin
            step_d = ~step_q;
            if (step_q) begin
               if (addr_q == ADDR_LAST) phase_d = r1w0_down;  // start down at top
               else addr_d = addr_q + 1'b1;
            end
         end
         r1w0_down: begin
            step_d = ~step_q;
            if (step_q) begin
               if (addr_q == '0) phase_d = r0_up;  // start up at bottom
               else addr_d = addr_q - 1'b1;
            end
         end
         r0_up: begin
            if (addr_q == ADDR_LAST) begin
               phase_d = finish;
               addr_d  = '0;
            end else addr_d = addr_q + 1'b1;
         end
         default: phase_d = idle;  // finish, last compare done
      endcase
   end

   //############################## access decode
   always_comb begin
      op.addr = addr_q;
      case (phase_q)
         r0w1_up:   begin op.rd = ~step_q; op.val =  step_q; end  // r0 then w1
         r1w0_down: begin op.rd = ~step_q; op.val = ~step_q; end  // r1 then w0
         r0_up:     begin op.rd = 1'b1;    op.val = 1'b0;    end
         default:   begin op.rd = 1'b0;    op.val = 1'b0;    end  // w0_up
      endcase
   end

   assign access   = phase_q inside {w0_up, r0w1_up, r1w0_down, r0_up};
   assign mem.en   = access;
   assign mem.we   = access & ~op.rd;
   assign mem.wem  = '1;             // full word writes
   assign mem.addr = op.addr;
   assign mem.din  = {DW{op.val}};

   //############################## registers
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         phase_q <= idle;
         addr_q  <= '0;
         step_q  <= 1'b0;
         cmp_q   <= 1'b0;
         done_q  <= 1'b0;
         fail_q  <= 1'b0;
      end else begin
         phase_q <= phase_d;
         addr_q  <= addr_d;
         step_q  <= step_d;
         cmp_q   <= access & op.rd;          // dout ready next cycle
         done_q  <= (phase_q == finish);     // after the last compare
         if (bist_start && phase_q == idle) fail_q <= 1'b0;
         else if (cmp_q && mem.dout != {DW{exp_q}}) fail_q <= 1'b1;  // sticky
      end
   end

   always_ff @(posedge clk) begin
      exp_q <= op.val;  // expected value of the read
   end

   assign bist_busy = (phase_q != idle);  // falls with done rising
   assign bist_done = done_q;
   assign bist_fail = fail_q;

   //############################## checks
   a_done_start: assert property (@(posedge clk) disable iff (!arst_n)
      bist_done |-> !bist_start)
      else $error("bist_march: start while done");

endmodule

// ==== source/mem_access_stage.sv ====
//##############################
// functional access stage
// one-entry request register
// byte enable to bit mask expansion
// read tag / valid aligned to dout
//##############################

module mem_access_stage
   import mem_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  logic     req_valid,  // one-cycle request strobe
   input  mem_req_t req,        // request fields
   input  logic     bist_busy,  // drop requests while high
   mem_if.master    mem,        // to the single-port wrapper
   output logic     rsp_valid,  // one-cycle read response strobe
   output mem_rsp_t rsp         // tag and read data
);

   localparam int NBYTES = $bits(be_t);  // byte lanes

   //############################## request register
   logic     req_vld_q;  // entry holds a request
   mem_req_t req_q;      // request payload
   logic     acc;        // access issued this cycle
   logic     rd_vld_q;   // read issued last cycle
   tag_t     rd_tag_q;   // its tag
   data_t    wem_exp;    // expanded bit mask

   assign acc = req_vld_q & ~bist_busy;  // late drop if BIST just took over

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         req_vld_q <= 1'b0;
         rd_vld_q  <= 1'b0;
      end else begin
         req_vld_q <= req_valid & ~bist_busy;  // ignore requests under BIST
         rd_vld_q  <= acc & ~req_q.we;         // reads only, writes are silent
      end
   end

   always_ff @(posedge clk) begin
      if (req_valid & ~bist_busy) req_q <= req;
      if (acc) rd_tag_q <= req_q.tag;  // follows the read into the RAM cycle
   end

   //############################## byte lanes
   always_comb begin
      for (int b = 0; b < NBYTES; b++) begin
         wem_exp[8*b +: 8] = {8{req_q.be[b]}};  // one bit per data bit
      end
   end

   assign mem.en   = acc;
   assign mem.we   = req_q.we;
   assign mem.wem  = wem_exp;
   assign mem.addr = req_q.addr;
   assign mem.din  = req_q.data;

   //############################## response
   assign rsp_valid = rd_vld_q;
   assign rsp       = '{tag: rd_tag_q, data: mem.dout};  // dout valid this cycle

endmodule

// ==== source/mem_sp.sv ====
//##############################
// single-port memory wrapper
// functional / BIST port select
// split into RAM read and write strobes
//##############################

module mem_sp
   import mem_pkg::*;
(
   input  logic  clk,
   input  logic  bist_en,  // BIST owns the array
   mem_if.memory func,     // functional access
   mem_if.memory bist      // BIST access
);

   localparam int NBYTES = $bits(be_t);  // byte lanes of a word

   //############################## port select
   logic  en;    // selected enable
   logic  we;    // selected global write
   data_t wem;   // selected bit mask
   addr_t addr;  // selected address
   data_t din;   // selected write data
   data_t dout;  // RAM read data

   assign en   = bist_en ? bist.en   : func.en;    // combinational, no added cycle
   assign we   = bist_en ? bist.we   : func.we;
   assign wem  = bist_en ? bist.wem  : func.wem;
   assign addr = bist_en ? bist.addr : func.addr;
   assign din  = bist_en ? bist.din  : func.din;

   //############################## array
   mem_ram u_ram (
      .clk     (clk),
      // read port, enable without write
      .rd_en   (en & ~we),
      .rd_addr (addr),
      .rd_dout (dout),
      // write port, enable with write
      .wr_en   (en & we),
      .wr_addr (addr),
      .wr_wem  (wem),
      .wr_din  (din)
   );

   // both sides see the same read word
   assign func.dout = dout;
   assign bist.dout = dout;

   //############################## checks
   // access stage must hold off while the march runs,
   // otherwise its access would be silently lost
   a_func_quiet: assert property (@(posedge clk) bist_en |-> !func.en)
      else $error("mem_sp: functional access during BIST");

   // functional writes stay byte-granular
   for (genvar b = 0; b < NBYTES; b++) begin : g_lane_chk
      a_lane_whole: assert property (@(posedge clk)
         (func.en && func.we) |-> (func.wem[8*b +: 8] inside {8'h00, 8'hff}))
         else $error("mem_sp: byte lane %0d partly enabled", b);
   end

endmodule

// ==== source/mem_ram.sv ====
//##############################
// behavioural RAM model
// registered read port
// bit-masked write port
//##############################
`include "mem_config.svh"

module mem_ram (
   input  logic               clk,
   // read port
   input  logic               rd_en,    // read strobe
   input  logic [`MEM_AW-1:0] rd_addr,  // read address
   output logic [`MEM_DW-1:0] rd_dout,  // held while rd_en low
   // write port
   input  logic               wr_en,    // write strobe
   input  logic [`MEM_AW-1:0] wr_addr,  // write address
   input  logic [`MEM_DW-1:0] wr_wem,   // bits to update
   input  logic [`MEM_DW-1:0] wr_din    // write data
);

   //############################## storage
   logic [`MEM_DW-1:0] ram [`MEM_DEPTH];  // undefined at power-up

   // merge new bits over old ones under the mask
   always_ff @(posedge clk) begin
      if (wr_en) begin
         ram[wr_addr] <= (ram[wr_addr] & ~wr_wem) | (wr_din & wr_wem);
      end
   end

   //############################## read
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_dout <= ram[rd_addr];  // one cycle latency
      end
   end

   //############################## checks
   // the single-port wrapper above splits one access, so a
   // collision here means the port decode is broken
   a_no_rd_wr: assert property (@(posedge clk) !(rd_en && wr_en))
      else $error("mem_ram: read and write in the same cycle");

endmodule

// ==== source/mem_if.sv ====
//##############################
// single-port memory access bundle
// master side drives the access
// memory side returns read data
//##############################
`include "mem_config.svh"

interface mem_if;

   logic              en;    // access taken on rising clk
   logic              we;    // global write enable
   logic [`MEM_DW-1:0] wem;  // per-bit write enable
   logic [`MEM_AW-1:0] addr; // word address
   logic [`MEM_DW-1:0] din;  // write data
   logic [`MEM_DW-1:0] dout; // read data, valid after the edge

   //############################## views
   modport master (
      output en,
      output we,
      output wem,
      output addr,
      output din,
      input  dout
   );

   modport memory (
      input  en,
      input  we,
      input  wem,
      input  addr,
      input  din,
      output dout
   );

endinterface

// ==== source/bist_pkg.sv ====
//##############################
// march test types
// phase encoding and per-cycle operation
//##############################

package bist_pkg;

   import mem_pkg::*;

   //############################## march elements
   typedef enum logic [2:0] {
      idle,       // waiting for start
      w0_up,      // write 0, ascending
      r0w1_up,    // read 0 then write 1, ascending
      r1w0_down,  // read 1 then write 0, descending
      r0_up,      // final read 0, ascending
      finish      // last compare drains here
   } march_phase_e;

   //############################## one access
   typedef struct packed {
      addr_t addr;  // current word
      logic  rd;    // 1 = read and compare, 0 = write
      logic  val;   // data value, all zeros or all ones
   } march_op_t;

endpackage

// ==== source/mem_pkg.sv ====
//##############################
// functional access types
// address, data, byte enable and tag words
// request and response structs
//##############################
`include "mem_config.svh"

package mem_pkg;

   //############################## basic words
   typedef logic [`MEM_AW-1:0]     addr_t;  // word address
   typedef logic [`MEM_DW-1:0]     data_t;  // data word, also bit mask
   typedef logic [`MEM_NBYTES-1:0] be_t;    // one bit per byte lane
   typedef logic [`MEM_TW-1:0]     tag_t;   // returned with read data

   //############################## request / response
   typedef struct packed {
      logic  we;    // 1 = write, 0 = read
      be_t   be;    // write byte lanes, ignored on reads
      addr_t addr;  // word address
      data_t data;  // write data
      tag_t  tag;   // echoed on the read response
   } mem_req_t;

   // read response, built next to the RAM output
   typedef struct packed {
      tag_t  tag;   // tag of the read
      data_t data;  // word read
   } mem_rsp_t;

endpackage

// ==== source/mem_config.svh ====
//##############################
// sizing macros for the memory subsystem
// data width, depth, address width,
// byte lane count and request tag width
//##############################
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

//############################## array geometry
`define MEM_DW      32                   // data word width in bits
`define MEM_DEPTH   64                   // words, power of two
`define MEM_AW      ($clog2(`MEM_DEPTH)) // word address width

//############################## request side
`define MEM_NBYTES  (`MEM_DW / 8)        // byte lanes per word
`define MEM_TW      4                    // request tag width

`endif
